//--- all.f
common/axi_rd_pkg.sv
common/dma_req_pkg.sv
hdl/rd_req_decode.sv
burst_issue/burst_issue.sv
hdl/rd_done_track.sv
hdl/axi_addr_manager.sv
bench/tb_clkgen.sv
bench/tb_axi_addr_manager.sv

//--- Makefile
TOP := tb_axi_addr_manager
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -Mdir obj_dir -f all.f
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Testbench passed" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/tb_axi_addr_manager.sv
module tb_axi_addr_manager
    import axi_rd_pkg::*, dma_req_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    // run bound from tests x bursts per test x cycles per burst, plus setup
    localparam int NUM_TESTS        = 6;
    localparam int MAX_BURSTS       = 64;
    localparam int CYCLES_PER_BURST = 50;
    localparam int WATCHDOG_CYCLES  = NUM_TESTS * MAX_BURSTS * CYCLES_PER_BURST + 800;
    // quiet cycles after done, a stray second pulse shows up here
    localparam int DRAIN_CYCLES     = 40;

    logic       aclk;
    logic       aresetn;
    logic       rd_cfg_ready       = 1'b0;
    outstd_t    rd_cfg_outstd      = '0;
    logic       rd_cfg_outstd_en   = 1'b0;
    rd_req_t    raddr_fifo_req     = '0;
    logic       raddr_fifo_empty   = 1'b1;
    logic       dma_raddr_burst_ok = 1'b0;
    logic       axi_burst_rdata_ok = 1'b0;
    logic       raddr_fifo_pop;
    logic       dma_trans_burst_avalid;
    addr_t      dma_trans_burst_addr;
    burst_len_t dma_trans_burst_len;
    beat_off_t  strb_first_beat_num;
    beat_off_t  strb_last_beat_num;
    logic       dma_trans_first_burst;
    logic       dma_trans_last_burst;
    logic       read_all_done;

    integer     seed = 32'hb4820b1a;
    rd_req_t    fifo_q[$];
    rd_req_t    stim_q[$];
    // expected bursts, then per-request totals and offsets
    addr_t      exp_addr_q[$];
    burst_len_t exp_len_q[$];
    int         exp_total_q[$];
    beat_off_t  exp_sf_q[$];
    beat_off_t  exp_sl_q[$];
    logic       exp_last_q[$];
    int         exp_sum     = 0;
    int         cur_limit   = 1;
    // slave model state
    int         pending     = 0;
    int         gap         = 0;
    // checker counts, cumulative over the run
    int         acc_total   = 0;
    int         pulse_total = 0;
    int         done_total  = 0;
    int         in_flight   = 0;
    int         dp_idx      = 0;
    logic       final_prev  = 1'b0;
    int         chk_err     = 0;
    int         main_err    = 0;
    int         tests_run   = 0;
    int         tests_bad   = 0;

    tb_clkgen u_clk (
        .aclk    (aclk),
        .aresetn (aresetn)
    );

    axi_addr_manager UUT (.*);

    // ======================================================================
    // reference and compare tasks
    // ======================================================================

    // burst list and offsets of one request
    function automatic void ref_plan(input rd_req_t r);
        int    off;
        int    words;
        int    lines;
        int    tail;
        int    i;
        addr_t a;
        off   = int'(r.addr % 32);
        words = (r.num_word == '0) ? 1 : int'(r.num_word);
        lines = (off + 4 * words + 31) / 32;
        tail  = lines % 16;
        a     = r.addr - addr_t'(off);
        for (i = 0; i < lines / 16; i++) begin
            exp_addr_q.push_back(a);
            exp_len_q.push_back(burst_len_t'(15));
            a = a + addr_t'(16 * 32);
        end
        if (tail != 0) begin
            exp_addr_q.push_back(a);
            exp_len_q.push_back(burst_len_t'(tail - 1));
        end
        exp_total_q.push_back(lines / 16 + ((tail != 0) ? 1 : 0));
        exp_sf_q.push_back(beat_off_t'(off));
        exp_sl_q.push_back(beat_off_t'((off + 4 * words) % 32));
        exp_last_q.push_back(r.last);
        exp_sum = exp_sum + exp_total_q[$];
    endfunction

    task automatic check_burst(input addr_t exp_addr, input burst_len_t exp_len,
                               inout int errs);
        if (dma_trans_burst_addr !== exp_addr) begin
            $display("FAIL dma_trans_burst_addr got %h expected %h",
                     dma_trans_burst_addr, exp_addr);
            errs++;
        end
        if (dma_trans_burst_len !== exp_len) begin
            $display("FAIL dma_trans_burst_len got %h expected %h",
                     dma_trans_burst_len, exp_len);
            errs++;
        end
    endtask

    task automatic check_strb(input beat_off_t exp_first, input beat_off_t exp_last,
                              inout int errs);
        if (strb_first_beat_num !== exp_first) begin
            $display("FAIL strb_first_beat_num got %h expected %h",
                     strb_first_beat_num, exp_first);
            errs++;
        end
        if (strb_last_beat_num !== exp_last) begin
            $display("FAIL strb_last_beat_num got %h expected %h",
                     strb_last_beat_num, exp_last);
            errs++;
        end
    endtask

    task automatic check_count(input string name, input burst_cnt_t got,
                               input burst_cnt_t exp, inout int errs);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp,
                              inout int errs);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            errs++;
        end
    endtask

    // ======================================================================
    // fifo and slave models
    // ======================================================================

    // show-ahead, a pop consumes the head shown during that cycle
    always @(posedge aclk) begin
        if (raddr_fifo_pop && (fifo_q.size() != 0)) begin
            fifo_q.delete(0);
        end
        raddr_fifo_empty <= (fifo_q.size() == 0);
        raddr_fifo_req   <= (fifo_q.size() != 0) ? fifo_q[0] : '0;
    end

    always @(posedge aclk) begin
        if (aresetn) begin
            // random address back-pressure
            dma_raddr_burst_ok <= (($unsigned($random(seed)) % 3) == 0);
            if (dma_trans_burst_avalid && dma_raddr_burst_ok) begin
                pending = pending + 1;
            end
            // data bursts complete in order, random gap between them
            if ((pending != 0) && (gap == 0)) begin
                axi_burst_rdata_ok <= 1'b1;
                pending = pending - 1;
                gap     = int'($unsigned($random(seed)) % 6);
            end else begin
                axi_burst_rdata_ok <= 1'b0;
                if (gap != 0) begin
                    gap = gap - 1;
                end
            end
        end
    end

    // ======================================================================
    // checker
    // ======================================================================

    always @(posedge aclk) begin
        logic final_now;
        final_now = 1'b0;
        if (aresetn) begin
            if (dma_trans_burst_avalid && dma_raddr_burst_ok) begin
                acc_total++;
                in_flight++;
                if (exp_addr_q.size() == 0) begin
                    $display("an address burst was accepted while none was expected");
                    chk_err++;
                end else begin
                    check_burst(exp_addr_q[0], exp_len_q[0], chk_err);
                    exp_addr_q.delete(0);
                    exp_len_q.delete(0);
                end
            end
            if (axi_burst_rdata_ok) begin
                pulse_total++;
                in_flight--;
                if (exp_total_q.size() == 0) begin
                    $display("a data burst completed with no request pending");
                    chk_err++;
                end else begin
                    // offsets stay loaded for the whole request
                    if (dp_idx == 0) begin
                        check_strb(exp_sf_q[0], exp_sl_q[0], chk_err);
                    end
                    check_flag("dma_trans_first_burst", dma_trans_first_burst,
                               dp_idx == 0, chk_err);
                    check_flag("dma_trans_last_burst", dma_trans_last_burst,
                               dp_idx == exp_total_q[0] - 1, chk_err);
                    dp_idx++;
                    if (dp_idx == exp_total_q[0]) begin
                        final_now = exp_last_q[0];
                        dp_idx    = 0;
                        exp_total_q.delete(0);
                        exp_sf_q.delete(0);
                        exp_sl_q.delete(0);
                        exp_last_q.delete(0);
                    end
                end
            end
            if (in_flight > cur_limit) begin
                $display("%0d bursts in flight, above the limit of %0d", in_flight, cur_limit);
                chk_err++;
            end
            // done belongs to the cycle right after the final data burst
            if (read_all_done) begin
                done_total++;
                if (!final_prev) begin
                    $display("read_all_done pulsed without a final data burst just before");
                    chk_err++;
                end
            end
            final_prev = final_now;
        end
    end

    // ======================================================================
    // test sequence
    // ======================================================================

    task automatic add_req(input addr_t a, input word_cnt_t n, input logic last);
        rd_req_t r;
        r.addr     = a;
        r.num_word = n;
        r.last     = last;
        stim_q.push_back(r);
    endtask

    task automatic report_test(input string name, input int err0);
        int errs;
        errs = chk_err + main_err - err0;
        tests_run++;
        if (errs != 0) begin
            tests_bad++;
        end
        $display("test %-16s %s  bursts %0d  errors %0d", name,
                 (errs == 0) ? "ok" : "FAILED", exp_sum, errs);
    endtask

    // one run, ends with the request flagged last
    task automatic run_test(input string name, input outstd_t lim, input logic en);
        int acc0;
        int pulse0;
        int done0;
        int err0;
        acc0    = acc_total;
        pulse0  = pulse_total;
        done0   = done_total;
        err0    = chk_err + main_err;
        exp_sum = 0;
        foreach (stim_q[i]) begin
            ref_plan(stim_q[i]);
        end
        cur_limit = (en && (lim != '0)) ? int'(lim) : 1;
        @(negedge aclk);
        foreach (stim_q[i]) begin
            fifo_q.push_back(stim_q[i]);
        end
        @(posedge aclk);
        rd_cfg_outstd    <= lim;
        rd_cfg_outstd_en <= en;
        rd_cfg_ready     <= 1'b1;
        @(posedge aclk);
        rd_cfg_ready <= 1'b0;
        while (done_total == done0) begin
            @(posedge aclk);
        end
        repeat (DRAIN_CYCLES) begin
            @(posedge aclk);
        end
        check_count("read_all_done pulses", burst_cnt_t'(done_total - done0),
                    burst_cnt_t'(1), main_err);
        check_count("accepted bursts", burst_cnt_t'(acc_total - acc0),
                    burst_cnt_t'(exp_sum), main_err);
        check_count("data bursts", burst_cnt_t'(pulse_total - pulse0),
                    burst_cnt_t'(exp_sum), main_err);
        if ((exp_addr_q.size() != 0) || (exp_total_q.size() != 0)) begin
            $display("the run ended with expected bursts still outstanding");
            main_err++;
        end
        if (fifo_q.size() != 0) begin
            $display("the run ended with requests left in the fifo");
            main_err++;
        end
        report_test(name, err0);
        stim_q.delete();
    endtask

    initial begin
        int i;
        int n;
        int t;
        int err0;
        wait (aresetn === 1'b1);
        @(posedge aclk);
        // idle outputs before any stimulus
        err0 = main_err;
        check_flag("raddr_fifo_pop", raddr_fifo_pop, 1'b0, main_err);
        check_flag("dma_trans_burst_avalid", dma_trans_burst_avalid, 1'b0, main_err);
        check_flag("dma_trans_first_burst", dma_trans_first_burst, 1'b0, main_err);
        check_flag("dma_trans_last_burst", dma_trans_last_burst, 1'b0, main_err);
        check_flag("read_all_done", read_all_done, 1'b0, main_err);
        check_burst('0, '0, main_err);
        check_strb('0, '0, main_err);
        report_test("reset", err0);

        // short and unaligned, one tail burst
        add_req(32'h0000_1234, 30'd10, 1'b1);
        run_test("short_unaligned", 4'd3, 1'b1);
        // full bursts then tail, three credits
        add_req(32'h0002_0008, 30'd300, 1'b1);
        run_test("long_outstd3", 4'd3, 1'b1);
        // outstanding off, single credit
        add_req(32'h0003_0010, 30'd520, 1'b1);
        run_test("long_outstd_off", 4'd3, 1'b0);
        // zero words, exactly one full burst, span ending on a beat
        add_req(32'h0000_401c, 30'd0, 1'b0);
        add_req(32'h0000_8000, 30'd128, 1'b0);
        add_req(32'h0000_9014, 30'd3, 1'b1);
        run_test("edge_counts", 4'd0, 1'b1);

        // random runs, drawn away from the clock edge
        for (t = 0; t < 2; t++) begin
            @(negedge aclk);
            n = 4 + int'($unsigned($random(seed)) % 4);
            for (i = 0; i < n; i++) begin
                add_req(addr_t'($random(seed)) & 32'h00ff_fffc,
                        word_cnt_t'($unsigned($random(seed)) % 600), i == n - 1);
            end
            run_test($sformatf("random_%0d", t),
                     outstd_t'($unsigned($random(seed)) % 5), 1'b1);
        end

        $display("tests %0d  failed %0d  errors %0d", tests_run, tests_bad,
                 chk_err + main_err);
        if ((chk_err + main_err) == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) begin
            @(posedge aclk);
        end
        $display("run stopped by the watchdog after %0d cycles", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

endmodule

//--- bench/tb_clkgen.sv
module tb_clkgen (
    output logic aclk,
    output logic aresetn
);
    timeunit 1ns;
    timeprecision 1ps;

    // 8 ns period
    localparam int HALF_PERIOD  = 4;
    localparam int RESET_CYCLES = 4;

    initial begin
        aclk = 1'b0;
        forever begin
            #HALF_PERIOD aclk = ~aclk;
        end
    end

    // reset low for the first few edges
    initial begin
        aresetn = 1'b0;
        repeat (RESET_CYCLES) begin
            @(posedge aclk);
        end
        aresetn <= 1'b1;
    end

endmodule

//--- hdl/axi_addr_manager.sv
module axi_addr_manager
    import axi_rd_pkg::*, dma_req_pkg::*;
(
    input  logic       aclk,
    input  logic       aresetn,

    // configuration
    input  logic       rd_cfg_ready,
    input  outstd_t    rd_cfg_outstd,
    input  logic       rd_cfg_outstd_en,

    // request fifo, show-ahead
    input  rd_req_t    raddr_fifo_req,
    input  logic       raddr_fifo_empty,
    output logic       raddr_fifo_pop,

    // address channel
    input  logic       dma_raddr_burst_ok,
    output logic       dma_trans_burst_avalid,
    output addr_t      dma_trans_burst_addr,
    output burst_len_t dma_trans_burst_len,

    // data channel completion
    input  logic       axi_burst_rdata_ok,

    // per-request status
    output beat_off_t  strb_first_beat_num,
    output beat_off_t  strb_last_beat_num,
    output logic       dma_trans_first_burst,
    output logic       dma_trans_last_burst,
    output logic       read_all_done
);

    logic        plan_valid;
    logic        plan_take;
    logic        req_busy;
    burst_plan_t plan;

    // ======================================================================
    // input side
    // ======================================================================

    rd_req_decode u_decode (
        .aclk             (aclk),
        .aresetn          (aresetn),
        .rd_cfg_ready     (rd_cfg_ready),
        .raddr_fifo_req   (raddr_fifo_req),
        .raddr_fifo_empty (raddr_fifo_empty),
        .raddr_fifo_pop   (raddr_fifo_pop),
        .plan_take        (plan_take),
        .plan_valid       (plan_valid),
        .plan             (plan)
    );

    // address bursts and credits
    burst_issue u_issue (
        .aclk                   (aclk),
        .aresetn                (aresetn),
        .plan_valid             (plan_valid),
        .plan                   (plan),
        .plan_take              (plan_take),
        .req_busy               (req_busy),
        .rd_cfg_outstd          (rd_cfg_outstd),
        .rd_cfg_outstd_en       (rd_cfg_outstd_en),
        .dma_raddr_burst_ok     (dma_raddr_burst_ok),
        .dma_trans_burst_avalid (dma_trans_burst_avalid),
        .dma_trans_burst_addr   (dma_trans_burst_addr),
        .dma_trans_burst_len    (dma_trans_burst_len),
        .axi_burst_rdata_ok     (axi_burst_rdata_ok)
    );

    // output side, loads on the same take as the issuer
    rd_done_track u_track (
        .aclk                  (aclk),
        .aresetn               (aresetn),
        .plan_take             (plan_take),
        .plan                  (plan),
        .axi_burst_rdata_ok    (axi_burst_rdata_ok),
        .req_busy              (req_busy),
        .strb_first_beat_num   (strb_first_beat_num),
        .strb_last_beat_num    (strb_last_beat_num),
        .dma_trans_first_burst (dma_trans_first_burst),
        .dma_trans_last_burst  (dma_trans_last_burst),
        .read_all_done         (read_all_done)
    );

endmodule

//--- hdl/rd_done_track.sv
module rd_done_track
    import axi_rd_pkg::*, dma_req_pkg::*;
(
    input  logic        aclk,
    input  logic        aresetn,

    // plan load from the issuer
    input  logic        plan_take,
    input  burst_plan_t plan,

    // data burst completion
    input  logic        axi_burst_rdata_ok,

    output logic        req_busy,
    output beat_off_t   strb_first_beat_num,
    output beat_off_t   strb_last_beat_num,
    output logic        dma_trans_first_burst,
    output logic        dma_trans_last_burst,
    output logic        read_all_done
);

    logic       busy_q;
    logic       last_q;
    logic       done_q;
    burst_cnt_t total_q;
    burst_cnt_t seen_q;
    logic       final_pulse;

    // ======================================================================
    // data burst accounting
    // ======================================================================

    // last data burst of the current request
    assign final_pulse = busy_q && axi_burst_rdata_ok &&
                         ((seen_q + burst_cnt_t'(1)) == total_q);

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            busy_q              <= 1'b0;
            last_q              <= 1'b0;
            done_q              <= 1'b0;
            total_q             <= '0;
            seen_q              <= '0;
            strb_first_beat_num <= '0;
            strb_last_beat_num  <= '0;
        end else begin
            done_q <= final_pulse && last_q;
            if (plan_take) begin
                busy_q  <= 1'b1;
                last_q  <= plan.last;
                seen_q  <= '0;
                // full bursts plus an optional tail
                total_q <= plan.num_full + burst_cnt_t'(plan.tail_beats != '0);
                strb_first_beat_num <= plan.strb_first;
                strb_last_beat_num  <= plan.strb_last;
            end else if (final_pulse) begin
                busy_q <= 1'b0;
                seen_q <= '0;
            end else if (busy_q && axi_burst_rdata_ok) begin
                seen_q <= seen_q + burst_cnt_t'(1);
            end
        end
    end

    // ======================================================================
    // markers
    // ======================================================================

    assign req_busy              = busy_q;
    // nothing completed yet
    assign dma_trans_first_burst = busy_q && (seen_q == '0);
    // one burst left to complete
    assign dma_trans_last_burst  = busy_q && ((total_q - seen_q) == burst_cnt_t'(1));
    assign read_all_done         = done_q;

endmodule

//--- burst_issue/burst_issue.sv
module burst_issue
    import axi_rd_pkg::*, dma_req_pkg::*;
(
    input  logic        aclk,
    input  logic        aresetn,

    // plan from the decoder
    input  logic        plan_valid,
    input  burst_plan_t plan,
    output logic        plan_take,

    // tracker still has data bursts pending
    input  logic        req_busy,

    // outstanding configuration, static during a run
    input  outstd_t     rd_cfg_outstd,
    input  logic        rd_cfg_outstd_en,

    // address channel
    input  logic        dma_raddr_burst_ok,
    output logic        dma_trans_burst_avalid,
    output addr_t       dma_trans_burst_addr,
    output burst_len_t  dma_trans_burst_len,

    // one pulse per completed data burst
    input  logic        axi_burst_rdata_ok
);

    issue_state_t state_q;
    issue_state_t state_d;
    addr_t        addr_q;
    burst_len_t   len_q;
    burst_len_t   len_d;
    logic         avalid_q;
    burst_cnt_t   full_left_q;
    logic [4:0]   tail_q;
    logic [4:0]   tail_d;
    outstd_t      credit_q;
    outstd_t      credit_d;
    outstd_t      credit_lim;
    logic         accept;

    // ======================================================================
    // handshakes
    // ======================================================================

    assign accept    = avalid_q && dma_raddr_burst_ok;
    // next request only once the previous one has drained its data
    assign plan_take = plan_valid && (state_q == ISSUE_IDLE) && !req_busy;

    // disabled or zero limit falls back to a single credit
    assign credit_lim = (rd_cfg_outstd_en && (rd_cfg_outstd != '0)) ?
                        rd_cfg_outstd : outstd_t'(1);

    // tail size as seen by this cycle's update
    assign tail_d = plan_take ? plan.tail_beats : tail_q;

    // ======================================================================
    // sequencing fsm
    // ======================================================================

    always_comb begin
        state_d = state_q;
        case (state_q)
            ISSUE_IDLE: begin
                // a plan always has at least one burst
                if (plan_take) begin
                    state_d = (plan.num_full != '0) ? ISSUE_FULL : ISSUE_TAIL;
                end
            end
            ISSUE_FULL: begin
                if (accept && (full_left_q == burst_cnt_t'(1))) begin
                    state_d = (tail_q != '0) ? ISSUE_TAIL : ISSUE_WAIT;
                end
            end
            ISSUE_TAIL: begin
                if (accept) begin
                    state_d = ISSUE_WAIT;
                end
            end
            ISSUE_WAIT: begin
                // tracker sees the last data burst
                if (!req_busy) begin
                    state_d = ISSUE_IDLE;
                end
            end
            default: state_d = ISSUE_IDLE;
        endcase
    end

    // credits, one per burst in flight
    always_comb begin
        credit_d = credit_q;
        if (plan_take) begin
            credit_d = credit_lim;
        end else if (accept && !axi_burst_rdata_ok) begin
            credit_d = credit_q - outstd_t'(1);
        end else if (!accept && axi_burst_rdata_ok) begin
            credit_d = credit_q + outstd_t'(1);
        end
    end

    // length follows the burst kind about to be presented
    always_comb begin
        len_d = len_q;
        if (state_d == ISSUE_FULL) begin
            len_d = FULL_BURST_LEN;
        end else if (state_d == ISSUE_TAIL) begin
            len_d = burst_len_t'(tail_d - 5'd1);
        end
    end

    // ======================================================================
    // registers
    // ======================================================================

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state_q     <= ISSUE_IDLE;
            avalid_q    <= 1'b0;
            credit_q    <= '0;
            len_q       <= '0;
            addr_q      <= '0;
            full_left_q <= '0;
            tail_q      <= '0;
        end else begin
            state_q  <= state_d;
            credit_q <= credit_d;
            len_q    <= len_d;
            tail_q   <= tail_d;
            // held high under back-pressure, dropped when credits run out
            avalid_q <= ((state_d == ISSUE_FULL) || (state_d == ISSUE_TAIL)) &&
                        (credit_d != '0);
            if (plan_take) begin
                addr_q      <= plan.base_addr;
                full_left_q <= plan.num_full;
            end else if (accept) begin
                // step past the beats just requested
                addr_q <= addr_q + ((addr_t'(len_q) + addr_t'(1)) << BEAT_SHIFT);
                if (state_q == ISSUE_FULL) begin
                    full_left_q <= full_left_q - burst_cnt_t'(1);
                end
            end
        end
    end

    assign dma_trans_burst_avalid = avalid_q;
    assign dma_trans_burst_addr   = addr_q;
    assign dma_trans_burst_len    = len_q;

endmodule

//--- hdl/rd_req_decode.sv
module rd_req_decode
    import axi_rd_pkg::*, dma_req_pkg::*;
(
    input  logic        aclk,
    input  logic        aresetn,

    // start pulse from configuration
    input  logic        rd_cfg_ready,

    // show-ahead request fifo
    input  rd_req_t     raddr_fifo_req,
    input  logic        raddr_fifo_empty,
    output logic        raddr_fifo_pop,

    // plan handshake towards the issuer
    input  logic        plan_take,
    output logic        plan_valid,
    output burst_plan_t plan
);

    logic                  run_q;
    logic                  plan_valid_q;
    burst_plan_t           plan_q;
    burst_plan_t           plan_d;
    word_cnt_t             eff_words;
    logic [BEAT_SHIFT-1:0] head_off;
    logic [32:0]           span_bytes;
    logic [32:0]           span_round;
    logic [27:0]           span_lines;

    // ======================================================================
    // beat-line arithmetic on the fifo head
    // ======================================================================

    // zero words still moves one beat
    assign eff_words = (raddr_fifo_req.num_word == '0) ? word_cnt_t'(1) : raddr_fifo_req.num_word;
    assign head_off  = raddr_fifo_req.addr[BEAT_SHIFT-1:0];

    // bytes from the beat start to the end of the request
    assign span_bytes = {28'b0, head_off} + {1'b0, eff_words, 2'b00};
    // round up to whole beats
    assign span_round = span_bytes + 33'(BEAT_BYTES - 1);
    assign span_lines = span_round[32:BEAT_SHIFT];

    always_comb begin
        plan_d.base_addr  = {raddr_fifo_req.addr[31:BEAT_SHIFT], {BEAT_SHIFT{1'b0}}};
        plan_d.num_full   = burst_cnt_t'(span_lines / MAX_BURST_BEATS);
        plan_d.tail_beats = 5'(span_lines % MAX_BURST_BEATS);
        // strobe offsets within the first and last beat
        plan_d.strb_first = beat_off_t'(head_off);
        plan_d.strb_last  = beat_off_t'(span_bytes[BEAT_SHIFT-1:0]);
        plan_d.last       = raddr_fifo_req.last;
    end

    // ======================================================================
    // pop and plan hold
    // ======================================================================

    // one request in flight towards the issuer at a time
    assign raddr_fifo_pop = !raddr_fifo_empty && run_q && !plan_valid_q;

    // run flag, stops popping once the final request is planned
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            run_q <= 1'b0;
        end else if (rd_cfg_ready) begin
            run_q <= 1'b1;
        end else if (raddr_fifo_pop && raddr_fifo_req.last) begin
            run_q <= 1'b0;
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            plan_valid_q <= 1'b0;
        end else if (raddr_fifo_pop) begin
            plan_valid_q <= 1'b1;
        end else if (plan_take) begin
            plan_valid_q <= 1'b0;
        end
    end

    // plan payload
    always_ff @(posedge aclk) begin
        if (raddr_fifo_pop) begin
            plan_q <= plan_d;
        end
    end

    assign plan_valid = plan_valid_q;
    assign plan       = plan_q;

endmodule

//--- common/dma_req_pkg.sv
// request-side structs and the issuer state encoding
package dma_req_pkg;

    import axi_rd_pkg::*;

    // ======================================================================
    // counts
    // ======================================================================

    // 32-bit words per request
    typedef logic [29:0] word_cnt_t;

    // bursts per request
    typedef logic [21:0] burst_cnt_t;

    // ======================================================================
    // request as popped from the address fifo
    // ======================================================================

    typedef struct packed {
        addr_t     addr;      // word-aligned byte address
        word_cnt_t num_word;  // 0 behaves as 1
        logic      last;      // final request of the run
    } rd_req_t;

    // ======================================================================
    // burst plan handed from decoder to issuer and tracker
    // ======================================================================

    typedef struct packed {
        addr_t      base_addr;   // request address rounded down to the beat
        burst_cnt_t num_full;    // bursts of 16 beats
        logic [4:0] tail_beats;  // beats in the short burst, 0 if none
        beat_off_t  strb_first;  // byte offset of first valid byte
        beat_off_t  strb_last;   // byte offset just past the last byte
        logic       last;
    } burst_plan_t;

    // issuer fsm
    typedef enum logic [1:0] {
        ISSUE_IDLE,
        ISSUE_FULL,
        ISSUE_TAIL,
        ISSUE_WAIT
    } issue_state_t;

endpackage

//--- common/axi_rd_pkg.sv
// widths and burst constants of the 256-bit axi read address channel
package axi_rd_pkg;

    // ======================================================================
    // bus-side vector types
    // ======================================================================

    // byte address on the address channel
    typedef logic [31:0] addr_t;

    // axi length field, beats minus one
    typedef logic [3:0]  burst_len_t;

    // byte offset inside one 32-byte beat
    typedef logic [5:0]  beat_off_t;

    // configured outstanding burst count
    typedef logic [3:0]  outstd_t;

    // ======================================================================
    // beat and burst geometry
    // ======================================================================

    // 256-bit data bus
    localparam int BEAT_BYTES = 32;
    // log2 of the beat size, used for address stepping
    localparam int BEAT_SHIFT = 5;

    // full bursts carry 16 beats
    localparam int MAX_BURST_BEATS = 16;
    localparam burst_len_t FULL_BURST_LEN = 4'd15;

endpackage
